//--- decode_pkg.sv
package decode_pkg;

    ////////////////////
    // widths
    ////////////////////

    // one instruction byte
    typedef logic [7:0]   byte_t;
    // fetch window, byte 0 sits in the top bits
    typedef logic [127:0] packet_t;
    typedef logic [31:0]  eip_t;
    // instruction length in bytes
    typedef logic [7:0]   length_t;
    typedef logic [31:0]  disp_t;
    // wide enough for a far pointer
    typedef logic [47:0]  imm_t;
    typedef logic [2:0]   reg_idx_t;
    typedef logic [2:0]   seg_idx_t;

    // segment numbers
    localparam seg_idx_t seg_es = 3'd0;
    localparam seg_idx_t seg_cs = 3'd1;
    localparam seg_idx_t seg_ss = 3'd2;
    localparam seg_idx_t seg_ds = 3'd3;
    localparam seg_idx_t seg_fs = 3'd4;
    localparam seg_idx_t seg_gs = 3'd5;

    // immediate size codes
    typedef logic [1:0] imm_sz_t;
    localparam imm_sz_t imm_none = 2'd0;
    localparam imm_sz_t imm_8    = 2'd1;
    // 4 bytes, 2 under the 66 prefix
    localparam imm_sz_t imm_full = 2'd2;
    // offset plus selector, 6 bytes or 4 under 66
    localparam imm_sz_t imm_ptr  = 2'd3;

    ////////////////////
    // structs
    ////////////////////

    typedef struct packed {
        logic       rep;
        logic       opsize_ovr;
        logic       seg_ovr;
        seg_idx_t   seg;
        logic [1:0] count;
    } prefix_info_t;

    typedef struct packed {
        logic    known;
        logic    is_double;
        logic    has_modrm;
        imm_sz_t imm_sz;
        logic    is_br;
    } opcode_info_t;

    typedef struct packed {
        reg_idx_t   r1;
        reg_idx_t   r2;
        reg_idx_t   r3;
        logic       use_r2;
        logic       use_r3;
        logic [1:0] scale;
        // displacement bytes, 0 1 or 4
        logic [2:0] disp_sz;
        // modrm + sib + displacement bytes
        logic [2:0] modrm_len;
    } modrm_info_t;

    typedef struct packed {
        logic is_init;
        eip_t init_eip;
        logic is_resteer;
        eip_t wb_eip;
        logic bp_taken;
        eip_t bp_eip;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        logic       known;
        logic       rep;
        logic       opsize_ovr;
        seg_idx_t   seg;
        reg_idx_t   r1;
        reg_idx_t   r2;
        reg_idx_t   r3;
        logic       use_r2;
        logic       use_r3;
        logic [1:0] scale;
        logic       is_br;
        disp_t      disp;
        imm_t       imm;
    } decode_out_t;

    ////////////////////
    // helpers
    ////////////////////

    // byte at window position idx, zero past the end
    function automatic byte_t get_byte(packet_t pkt, int idx);
        if (idx < 16) begin
            return pkt[127 - 8*idx -: 8];
        end
        return '0;
    endfunction

    // immediate bytes for a size code
    function automatic logic [2:0] imm_bytes(imm_sz_t sz, logic opsize_ovr);
        case (sz)
            imm_8:    return 3'd1;
            imm_full: return opsize_ovr ? 3'd2 : 3'd4;
            imm_ptr:  return opsize_ovr ? 3'd4 : 3'd6;
            default:  return 3'd0;
        endcase
    endfunction

endpackage

//--- prefix_decode.sv
`timescale 1ns/1ps

module prefix_decode
    import decode_pkg::*;
#(
    parameter int max_prefixes = 3
) (
    input  packet_t      packet,
    output prefix_info_t prefix
);

    ////////////////////
    // prefix scan
    ////////////////////

    // walks the leading bytes in order
    // the first non-prefix byte ends the scan
    always_comb begin
        byte_t b;
        logic  scanning;
        logic  hit;
        prefix      = '0;
        prefix.seg  = seg_ds;
        scanning    = 1'b1;
        for (int i = 0; i < max_prefixes; i++) begin
            b   = get_byte(packet, i);
            hit = 1'b1;
            if (scanning) begin
                case (b)
                    // rep
                    8'hF3: prefix.rep = 1'b1;
                    // operand size
                    8'h66: prefix.opsize_ovr = 1'b1;
                    // segment overrides, last one wins
                    8'h26: prefix.seg = seg_es;
                    8'h2E: prefix.seg = seg_cs;
                    8'h36: prefix.seg = seg_ss;
                    8'h3E: prefix.seg = seg_ds;
                    8'h64: prefix.seg = seg_fs;
                    8'h65: prefix.seg = seg_gs;
                    default: hit = 1'b0;
                endcase
                // note any segment prefix
                if (hit && b != 8'hF3 && b != 8'h66) begin
                    prefix.seg_ovr = 1'b1;
                end
                if (hit) begin
                    prefix.count = prefix.count + 2'd1;
                end else begin
                    // opcode reached
                    scanning = 1'b0;
                end
            end
        end
    end

endmodule

//--- opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode
    import decode_pkg::*;
(
    input  packet_t      packet,
    input  prefix_info_t prefix,
    output opcode_info_t opcode
);

    // opcode sits right after the prefixes
    byte_t op_byte;
    // second byte, only meaningful after 0F
    byte_t op_byte2;

    assign op_byte  = get_byte(packet, int'(prefix.count));
    assign op_byte2 = get_byte(packet, int'(prefix.count) + 1);

    ////////////////////
    // opcode table
    ////////////////////

    always_comb begin
        // unsupported codes leave everything low
        opcode = '0;
        case (op_byte)
            // nop
            8'h90: begin
                opcode.known = 1'b1;
            end
            // add r/m, r
            8'h01: begin
                opcode.known     = 1'b1;
                opcode.has_modrm = 1'b1;
            end
            // add eax, imm
            8'h05: begin
                opcode.known  = 1'b1;
                opcode.imm_sz = imm_full;
            end
            // add r/m, imm
            8'h81: begin
                opcode.known     = 1'b1;
                opcode.has_modrm = 1'b1;
                opcode.imm_sz    = imm_full;
            end
            // add r/m, imm8
            8'h83: begin
                opcode.known     = 1'b1;
                opcode.has_modrm = 1'b1;
                opcode.imm_sz    = imm_8;
            end
            // call rel
            8'hE8: begin
                opcode.known  = 1'b1;
                opcode.imm_sz = imm_full;
                opcode.is_br  = 1'b1;
            end
            // jmp rel8
            8'hEB: begin
                opcode.known  = 1'b1;
                opcode.imm_sz = imm_8;
                opcode.is_br  = 1'b1;
            end
            // jmp far ptr
            8'hEA: begin
                opcode.known  = 1'b1;
                opcode.imm_sz = imm_ptr;
                opcode.is_br  = 1'b1;
            end
            // two byte escape, only imul r, r/m
            8'h0F: begin
                if (op_byte2 == 8'hAF) begin
                    opcode.known     = 1'b1;
                    opcode.is_double = 1'b1;
                    opcode.has_modrm = 1'b1;
                end
            end
            default: begin
                opcode = '0;
            end
        endcase
    end

endmodule

//--- modrm_decode.sv
`timescale 1ns/1ps

module modrm_decode
    import decode_pkg::*;
(
    input  packet_t      packet,
    input  prefix_info_t prefix,
    input  opcode_info_t opcode,
    output modrm_info_t  modrm,
    output length_t      length
);

    // modrm follows the one or two opcode bytes
    logic [3:0] modrm_pos;
    byte_t      modrm_byte;
    byte_t      sib_byte;
    logic [2:0] imm_len;

    assign modrm_pos  = 4'(prefix.count) + (opcode.is_double ? 4'd2 : 4'd1);
    assign modrm_byte = get_byte(packet, int'(modrm_pos));
    assign sib_byte   = get_byte(packet, int'(modrm_pos) + 1);

    ////////////////////
    // modrm and sib
    ////////////////////

    always_comb begin
        logic [1:0] mode;
        reg_idx_t   rm;
        reg_idx_t   base;
        reg_idx_t   index;
        logic       has_sib;
        mode    = modrm_byte[7:6];
        rm      = modrm_byte[2:0];
        base    = sib_byte[2:0];
        index   = sib_byte[5:3];
        has_sib = 1'b0;
        modrm   = '0;
        if (opcode.has_modrm) begin
            // reg field always names r1
            modrm.r1 = modrm_byte[5:3];
            if (mode == 2'b11) begin
                // register direct
                modrm.r2     = rm;
                modrm.use_r2 = 1'b1;
            end else if (rm == 3'b100) begin
                has_sib     = 1'b1;
                modrm.scale = sib_byte[7:6];
                // base 101 under mod 00 means disp32, no base
                if (!(base == 3'b101 && mode == 2'b00)) begin
                    modrm.r2     = base;
                    modrm.use_r2 = 1'b1;
                end else begin
                    modrm.disp_sz = 3'd4;
                end
                // index 100 means no index
                if (index != 3'b100) begin
                    modrm.r3     = index;
                    modrm.use_r3 = 1'b1;
                end
            end else if (mode == 2'b00 && rm == 3'b101) begin
                // absolute disp32
                modrm.disp_sz = 3'd4;
            end else begin
                modrm.r2     = rm;
                modrm.use_r2 = 1'b1;
            end
            // disp size from mod
            if (mode == 2'b01) begin
                modrm.disp_sz = 3'd1;
            end else if (mode == 2'b10) begin
                modrm.disp_sz = 3'd4;
            end
            modrm.modrm_len = 3'd1 + 3'(has_sib) + modrm.disp_sz;
        end
    end

    ////////////////////
    // length
    ////////////////////

    assign imm_len = imm_bytes(opcode.imm_sz, prefix.opsize_ovr);

    // prefixes + opcode + modrm/sib/disp + immediate
    always_comb begin
        length = '0;
        if (opcode.known) begin
            length = length_t'(prefix.count)
                   + (opcode.is_double ? length_t'(2) : length_t'(1))
                   + length_t'(modrm.modrm_len)
                   + length_t'(imm_len);
        end
    end

endmodule

//--- operand_extract.sv
`timescale 1ns/1ps

module operand_extract
    import decode_pkg::*;
(
    input  packet_t      packet,
    input  prefix_info_t prefix,
    input  opcode_info_t opcode,
    input  modrm_info_t  modrm,
    output disp_t        disp,
    output imm_t         imm
);

    // little endian read of nbytes at pos
    // sign bit taken from the last byte read
    function automatic imm_t read_le(packet_t pkt, int pos, int nbytes);
        imm_t  val;
        byte_t b;
        logic  sign;
        val  = '0;
        sign = 1'b0;
        for (int k = 0; k < 6; k++) begin
            if (k < nbytes) begin
                b            = get_byte(pkt, pos + k);
                val[8*k +: 8] = b;
                sign         = b[7];
            end else begin
                val[8*k +: 8] = {8{sign}};
            end
        end
        return val;
    endfunction

    ////////////////////
    // field positions
    ////////////////////

    logic [4:0] disp_pos;
    logic [4:0] imm_pos;
    logic [2:0] imm_len;
    imm_t       disp_wide;

    // skip prefixes, opcode bytes, modrm and sib
    // modrm_len minus disp_sz leaves just the modrm/sib bytes
    assign disp_pos = 5'(prefix.count)
                    + (opcode.is_double ? 5'd2 : 5'd1)
                    + 5'(modrm.modrm_len - modrm.disp_sz);

    // immediate comes after the displacement
    assign imm_pos = disp_pos + 5'(modrm.disp_sz);
    assign imm_len = imm_bytes(opcode.imm_sz, prefix.opsize_ovr);

    ////////////////////
    // extraction
    ////////////////////

    // zero sizes give zero values
    assign disp_wide = read_le(packet, int'(disp_pos), int'(modrm.disp_sz));
    assign disp      = disp_wide[31:0];
    assign imm       = read_le(packet, int'(imm_pos), int'(imm_len));

endmodule

//--- eip_unit.sv
`timescale 1ns/1ps

module eip_unit
    import decode_pkg::*;
#(
    parameter eip_t reset_eip = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  logic      known,
    input  length_t   length,
    input  redirect_t redirect,
    input  logic      queue_full,
    output eip_t      eip_out,
    output eip_t      latched_eip,
    output logic      stall
);

    logic    is_redirect;
    eip_t    redirect_eip;
    length_t counted_length;
    logic    load;

    ////////////////////
    // redirect select
    ////////////////////

    assign is_redirect = redirect.is_init | redirect.is_resteer | redirect.bp_taken;

    // init over resteer over predicted taken
    always_comb begin
        if (redirect.is_init) begin
            redirect_eip = redirect.init_eip;
        end else if (redirect.is_resteer) begin
            redirect_eip = redirect.wb_eip;
        end else begin
            redirect_eip = redirect.bp_eip;
        end
    end

    ////////////////////
    // advance and stall
    ////////////////////

    // only a valid, known instruction moves eip
    assign counted_length = (valid & known) ? length : '0;
    assign eip_out        = latched_eip + eip_t'(counted_length);

    // back-pressure from the downstream queue
    assign stall = valid & queue_full;
    // redirects load even while stalled
    assign load  = is_redirect | (valid & ~stall);

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_eip <= reset_eip;
        end else if (load) begin
            latched_eip <= is_redirect ? redirect_eip : eip_out;
        end
    end

endmodule

//--- decode_top.sv
`timescale 1ns/1ps

module decode_top
    import decode_pkg::*;
#(
    parameter int   max_prefixes = 3,
    parameter eip_t reset_eip    = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  packet_t     packet,
    input  logic        valid,
    input  redirect_t   redirect,
    input  logic        queue_full,
    output decode_out_t decoded,
    output length_t     d_length,
    output eip_t        eip_out,
    output eip_t        latched_eip,
    output logic        stall
);

    prefix_info_t prefix_info;
    opcode_info_t opcode_info;
    modrm_info_t  modrm_info;
    disp_t        disp;
    imm_t         imm;

    ////////////////////
    // decoders
    ////////////////////

    prefix_decode #(
        .max_prefixes (max_prefixes)
    ) prefix_decode_i (
        .packet (packet),
        .prefix (prefix_info)
    );

    opcode_decode opcode_decode_i (
        .packet (packet),
        .prefix (prefix_info),
        .opcode (opcode_info)
    );

    // also produces the instruction length
    modrm_decode modrm_decode_i (
        .packet (packet),
        .prefix (prefix_info),
        .opcode (opcode_info),
        .modrm  (modrm_info),
        .length (d_length)
    );

    operand_extract operand_extract_i (
        .packet (packet),
        .prefix (prefix_info),
        .opcode (opcode_info),
        .modrm  (modrm_info),
        .disp   (disp),
        .imm    (imm)
    );

    ////////////////////
    // eip
    ////////////////////

    eip_unit #(
        .reset_eip (reset_eip)
    ) eip_unit_i (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .known       (opcode_info.known),
        .length      (d_length),
        .redirect    (redirect),
        .queue_full  (queue_full),
        .eip_out     (eip_out),
        .latched_eip (latched_eip),
        .stall       (stall)
    );

    // decoded bundle
    always_comb begin
        decoded            = '0;
        decoded.valid      = valid;
        decoded.known      = opcode_info.known;
        decoded.rep        = prefix_info.rep;
        decoded.opsize_ovr = prefix_info.opsize_ovr;
        decoded.seg        = prefix_info.seg;
        decoded.r1         = modrm_info.r1;
        decoded.r2         = modrm_info.r2;
        decoded.r3         = modrm_info.r3;
        decoded.use_r2     = modrm_info.use_r2;
        decoded.use_r3     = modrm_info.use_r3;
        decoded.scale      = modrm_info.scale;
        decoded.is_br      = opcode_info.is_br;
        decoded.disp       = disp;
        decoded.imm        = imm;
    end

endmodule

//--- decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts
    import decode_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      valid,
    input logic      known,
    input length_t   d_length,
    input logic      stall,
    input eip_t      latched_eip,
    input redirect_t redirect
);

    logic any_redirect;
    // failed property count
    int   fail_count;

    initial fail_count = 0;

    assign any_redirect = redirect.is_init | redirect.is_resteer | redirect.bp_taken;

    ////////////////////
    // properties
    ////////////////////

    // back-pressure only with a valid packet
    stall_needs_valid: assert property (@(posedge clk) disable iff (reset)
        stall |-> valid)
        else begin
            fail_count++;
            $error("stall high while valid is low");
        end

    // unsupported opcode has no length
    unknown_zero_len: assert property (@(posedge clk) disable iff (reset)
        !known |-> d_length == '0)
        else begin
            fail_count++;
            $error("nonzero length for an unknown opcode");
        end

    // idle and no redirect, eip holds
    idle_holds_eip: assert property (@(posedge clk) disable iff (reset)
        (!valid && !any_redirect) |=> $stable(latched_eip))
        else begin
            fail_count++;
            $error("latched_eip moved while idle");
        end

endmodule

bind decode_top decode_asserts decode_asserts_i (
    .clk         (clk),
    .reset       (reset),
    .valid       (valid),
    .known       (decoded.known),
    .d_length    (d_length),
    .stall       (stall),
    .latched_eip (latched_eip),
    .redirect    (redirect)
);

//--- decode_tb.sv
`timescale 1ns/1ps

module decode_tb import decode_pkg::*; ();

    localparam eip_t start_eip  = 32'h0000_1000;
    localparam int   wait_limit = 20;

    // one table row, instruction bytes right aligned
    typedef struct packed {
        logic [127:0] bytes;
        logic [4:0]   nbytes;
        length_t      len;
        reg_idx_t     r1;
        reg_idx_t     r2;
        reg_idx_t     r3;
        logic [1:0]   uses;
        logic [1:0]   scale;
        seg_idx_t     seg;
        logic         rep;
        logic         opsize;
        disp_t        disp;
        imm_t         imm;
        logic         known;
        logic         is_br;
    } case_t;

    logic        clk;
    logic        reset;
    packet_t     packet;
    logic        valid;
    redirect_t   redirect;
    logic        queue_full;
    decode_out_t decoded;
    length_t     d_length;
    eip_t        eip_out;
    eip_t        latched_eip;
    logic        stall;

    case_t  cases[$];
    eip_t   model_eip;
    integer seed;
    int     mismatch_count;
    int     other_count;
    int     assert_count;

    decode_top #(
        .max_prefixes (3),
        .reset_eip    (start_eip)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .packet      (packet),
        .valid       (valid),
        .redirect    (redirect),
        .queue_full  (queue_full),
        .decoded     (decoded),
        .d_length    (d_length),
        .eip_out     (eip_out),
        .latched_eip (latched_eip),
        .stall       (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic add_case(input logic [127:0] bytes, input int nbytes, input int len,
                            input reg_idx_t r1, input reg_idx_t r2, input reg_idx_t r3,
                            input logic [1:0] uses, input logic [1:0] scale,
                            input seg_idx_t seg, input logic rep, input logic opsize,
                            input disp_t disp, input imm_t imm, input logic known,
                            input logic is_br);
        case_t c;
        c = '{bytes, nbytes[4:0], len[7:0], r1, r2, r3, uses, scale, seg, rep, opsize,
              disp, imm, known, is_br};
        cases.push_back(c);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // eip register against the local model
    task automatic check_eip();
        check_field("latched_eip", latched_eip, model_eip);
    endtask

    // left align the bytes, random filler behind them
    task automatic drive_case(input case_t c);
        packet_t p;
        byte_t   b;
        p = c.bytes << (8 * (16 - int'(c.nbytes)));
        for (int k = int'(c.nbytes); k < 16; k++) begin
            b = byte_t'($random(seed));
            p[127 - 8*k -: 8] = b;
        end
        packet     = p;
        valid      = 1'b1;
        queue_full = 1'b0;
        redirect   = '0;
    endtask

    task automatic check_case(input case_t c, input int idx);
        string tag;
        tag = $sformatf("case %0d", idx);
        check_field({tag, " d_length"}, d_length, c.len);
        check_field({tag, " known"}, decoded.known, c.known);
        check_field({tag, " valid"}, decoded.valid, 1'b1);
        check_field({tag, " rep"}, decoded.rep, c.rep);
        check_field({tag, " opsize_ovr"}, decoded.opsize_ovr, c.opsize);
        check_field({tag, " seg"}, decoded.seg, c.seg);
        check_field({tag, " r1"}, decoded.r1, c.r1);
        check_field({tag, " r2"}, decoded.r2, c.r2);
        check_field({tag, " r3"}, decoded.r3, c.r3);
        check_field({tag, " use_r2"}, decoded.use_r2, c.uses[1]);
        check_field({tag, " use_r3"}, decoded.use_r3, c.uses[0]);
        check_field({tag, " scale"}, decoded.scale, c.scale);
        check_field({tag, " is_br"}, decoded.is_br, c.is_br);
        check_field({tag, " disp"}, decoded.disp, c.disp);
        check_field({tag, " imm"}, decoded.imm, c.imm);
        check_field({tag, " eip_out"}, eip_out, model_eip + eip_t'(c.len));
        check_field({tag, " stall"}, stall, 1'b0);
    endtask

    task automatic wait_for_eip(input eip_t target);
        int n;
        n = 0;
        while (latched_eip !== target && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        assert (latched_eip === target) else begin
            other_count++;
            $display("timeout: latched_eip never reached the reset address");
        end
    endtask

    // flags are init, resteer, predicted taken
    task automatic run_redirect(input logic [2:0] flags, input logic qf, input eip_t target);
        @(negedge clk);
        check_eip();
        packet              = {8'h90, 120'h0};
        valid               = 1'b1;
        queue_full          = qf;
        redirect            = '0;
        redirect.is_init    = flags[2];
        redirect.init_eip   = 32'h0000_8000;
        redirect.is_resteer = flags[1];
        redirect.wb_eip     = 32'h0000_9000;
        redirect.bp_taken   = flags[0];
        redirect.bp_eip     = 32'h0000_a000;
        #40;
        check_field("stall", stall, qf);
        model_eip = target;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        seed           = 32'h6993025b;
        mismatch_count = 0;
        other_count    = 0;
        assert_count   = 0;
        reset          = 1'b1;
        packet         = '0;
        valid          = 1'b0;
        redirect       = '0;
        queue_full     = 1'b0;

        // prefixes
        add_case(128'h90, 1, 1, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0, 48'h0, 1, 0);
        add_case(128'hF3_90, 2, 2, 0, 0, 0, 2'b00, 0, seg_ds, 1, 0, 32'h0, 48'h0, 1, 0);
        add_case(128'h66_2E_90, 3, 3, 0, 0, 0, 2'b00, 0, seg_cs, 0, 1, 32'h0, 48'h0, 1, 0);
        add_case(128'hF3_26_64_90, 4, 4, 0, 0, 0, 2'b00, 0, seg_fs, 1, 0, 32'h0, 48'h0,
                 1, 0);
        add_case(128'h36_05_78_56_34_12, 6, 6, 0, 0, 0, 2'b00, 0, seg_ss, 0, 0, 32'h0,
                 48'h0000_1234_5678, 1, 0);
        add_case(128'h66_05_34_F2, 4, 4, 0, 0, 0, 2'b00, 0, seg_ds, 0, 1, 32'h0,
                 48'hFFFF_FFFF_F234, 1, 0);
        // modrm and sib forms
        add_case(128'h01_D8, 2, 2, 3, 0, 0, 2'b10, 0, seg_ds, 0, 0, 32'h0, 48'h0, 1, 0);
        add_case(128'h01_4B_10, 3, 3, 1, 3, 0, 2'b10, 0, seg_ds, 0, 0, 32'h10, 48'h0, 1, 0);
        add_case(128'h01_93_F0_FF_FF_FF, 6, 6, 2, 3, 0, 2'b10, 0, seg_ds, 0, 0,
                 32'hFFFF_FFF0, 48'h0, 1, 0);
        add_case(128'h01_0D_78_56_34_12, 6, 6, 1, 0, 0, 2'b00, 0, seg_ds, 0, 0,
                 32'h1234_5678, 48'h0, 1, 0);
        add_case(128'h01_44_24_08, 4, 4, 0, 4, 0, 2'b10, 0, seg_ds, 0, 0, 32'h8, 48'h0,
                 1, 0);
        add_case(128'h01_04_8D_00_10_00_00, 7, 7, 0, 0, 1, 2'b01, 2, seg_ds, 0, 0,
                 32'h1000, 48'h0, 1, 0);
        add_case(128'h0F_AF_44_B3_FC, 5, 5, 0, 3, 6, 2'b11, 2, seg_ds, 0, 0,
                 32'hFFFF_FFFC, 48'h0, 1, 0);
        // immediates and branches
        add_case(128'h83_C1_FF, 3, 3, 0, 1, 0, 2'b10, 0, seg_ds, 0, 0, 32'h0,
                 48'hFFFF_FFFF_FFFF, 1, 0);
        add_case(128'h83_40_04_F0, 4, 4, 0, 0, 0, 2'b10, 0, seg_ds, 0, 0, 32'h4,
                 48'hFFFF_FFFF_FFF0, 1, 0);
        add_case(128'h81_C2_00_00_00_80, 6, 6, 0, 2, 0, 2'b10, 0, seg_ds, 0, 0, 32'h0,
                 48'hFFFF_8000_0000, 1, 0);
        add_case(128'h66_81_C2_34_12, 5, 5, 0, 2, 0, 2'b10, 0, seg_ds, 0, 1, 32'h0,
                 48'h1234, 1, 0);
        add_case(128'hEA_78_56_34_12_08_00, 7, 7, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0,
                 48'h0008_1234_5678, 1, 1);
        add_case(128'h66_EA_34_12_08_00, 6, 6, 0, 0, 0, 2'b00, 0, seg_ds, 0, 1, 32'h0,
                 48'h0008_1234, 1, 1);
        add_case(128'hE8_10_00_00_00, 5, 5, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0,
                 48'h10, 1, 1);
        add_case(128'hEB_FE, 2, 2, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0,
                 48'hFFFF_FFFF_FFFE, 1, 1);
        // unsupported opcodes
        add_case(128'hC3, 1, 0, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0, 48'h0, 0, 0);
        add_case(128'h0F_05, 2, 0, 0, 0, 0, 2'b00, 0, seg_ds, 0, 0, 32'h0, 48'h0, 0, 0);
        add_case(128'hF3_C3, 2, 0, 0, 0, 0, 2'b00, 0, seg_ds, 1, 0, 32'h0, 48'h0, 0, 0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset     = 1'b0;
        model_eip = start_eip;
        wait_for_eip(start_eip);
        #40;
        // idle, so no back-pressure
        check_field("stall", stall, 1'b0);
        check_field("valid", decoded.valid, 1'b0);

        // table, eip checked one edge later
        foreach (cases[i]) begin
            @(negedge clk);
            check_eip();
            drive_case(cases[i]);
            #40;
            check_case(cases[i], i);
            model_eip = model_eip + eip_t'(cases[i].len);
        end

        // queue full holds eip
        for (int s = 0; s < 3; s++) begin
            @(negedge clk);
            check_eip();
            drive_case(cases[4]);
            queue_full = 1'b1;
            #40;
            check_field("stall", stall, 1'b1);
        end

        // priority init, resteer, predicted taken
        run_redirect(3'b111, 1'b0, 32'h0000_8000);
        run_redirect(3'b011, 1'b0, 32'h0000_9000);
        run_redirect(3'b001, 1'b0, 32'h0000_a000);
        // redirect wins over a stall
        run_redirect(3'b011, 1'b1, 32'h0000_9000);
        run_redirect(3'b101, 1'b1, 32'h0000_8000);

        @(negedge clk);
        check_eip();
        packet     = '0;
        valid      = 1'b0;
        redirect   = '0;
        queue_full = 1'b0;
        @(negedge clk);
        check_eip();

        // failed properties in the bound checker
        assert_count = dut_i.decode_asserts_i.fail_count;

        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_count, other_count, assert_count);
        if (mismatch_count == 0 && other_count == 0 && assert_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
decode_pkg.sv
prefix_decode.sv
opcode_decode.sv
modrm_decode.sv
operand_extract.sv
eip_unit.sv
decode_top.sv
decode_asserts.sv
decode_tb.sv
